// ==== exu_defs.svh ====
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// ************************************************************************
// execute stage widths
// ************************************************************************

// data path and pc width
`define XLEN        64

// register index width
`define REG_ADDR_W  5

// x0 reads as zero, so it never forwards and never conflicts
`define ZERO_REG    {`REG_ADDR_W{1'b0}}

`endif

// ==== exu_pkg.sv ====
`include "exu_defs.svh"

package exu_pkg;

    // operands, results and pcs
    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // one code per alu function, compares share the same datapath
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_sll  = 4'h5,
        op_srl  = 4'h6,
        op_sra  = 4'h7,
        op_slt  = 4'h8,
        op_sltu = 4'h9,
        op_beq  = 4'ha,
        op_bne  = 4'hb,
        op_blt  = 4'hc,
        op_bge  = 4'hd,
        op_bltu = 4'he,
        op_bgeu = 4'hf
    } alu_op_t;

endpackage

// ==== exu_ifs.sv ====
`timescale 1ns/1ps

// view of the execute/load-store output register
interface ex_ls_if import exu_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     dest_wen;
    logic     load_valid;
    word_t    result;

    // valid owner, also checks rd for load-use
    modport ctrl (output valid, input rd, input dest_wen, input load_valid);

    // payload bank
    modport regs (output rd, output dest_wen, output load_valid, output result);

    // forwarding reads the whole register
    modport fwd (
        input valid,
        input rd,
        input dest_wen,
        input load_valid,
        input result
    );
endinterface

// writeback bypass
interface wb_fwd_if import exu_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     dest_wen;
    word_t    data;

    modport fwd (input valid, input rd, input dest_wen, input data);
endinterface

// ==== exu_ctrl.sv ====
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_ctrl import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     decode_valid,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     branch_valid,
    input  logic     jump_valid,
    input  logic     branch_taken,
    input  logic     ls_flush,
    input  logic     ls_ready,
    ex_ls_if.ctrl    ex,
    output logic     decode_ready,
    output logic     flush,
    output logic     jump_flag
);
    logic ex_load_busy;
    logic conflict;
    logic out_en;
    logic redirect;
    logic jump_done;

    // load in ex has no data yet, sources waiting on it must stall
    assign ex_load_busy = ex.valid && ex.dest_wen && ex.load_valid;
    assign conflict     = ex_load_busy &&
                          (((rs1 != `ZERO_REG) && (rs1 == ex.rd)) ||
                           ((rs2 != `ZERO_REG) && (rs2 == ex.rd)));

    // output register free or draining this cycle
    assign out_en       = !ex.valid || ls_ready;
    assign decode_ready = decode_valid && out_en && !conflict;
    assign flush        = ls_flush;

    assign redirect  = jump_valid || (branch_valid && branch_taken);
    assign jump_flag = decode_valid && redirect && !jump_done && !conflict;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end else if (flush) begin
            ex.valid <= 1'b0;
        end else if (out_en) begin
            ex.valid <= decode_ready;
        end
    end

    // one redirect per instruction, re-armed on accept or flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_done <= 1'b0;
        end else if (flush || decode_ready) begin
            jump_done <= 1'b0;
        end else if (jump_flag) begin
            jump_done <= 1'b1;
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************

    a_jump_single: assert property (@(posedge clk) disable iff (!rst_n)
        (jump_flag && !decode_ready && !flush) |=> !jump_flag);

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ex.valid);

endmodule

// ==== operand_fwd.sv ====
`timescale 1ns/1ps
`include "exu_defs.svh"

module operand_fwd import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     decode_valid,
    input  logic     decode_ready,
    input  logic     flush,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     jalr,
    input  word_t    operand1,
    input  word_t    operand2,
    input  word_t    operand3,
    ex_ls_if.fwd     ex,
    wb_fwd_if.fwd    wb,
    output word_t    src_a,
    output word_t    src_b,
    output word_t    target_base
);
    reg_idx_t   src_idx [2];
    word_t      dflt [2];
    word_t      fwd [2];
    word_t      hold_data [2];
    logic [1:0] hold_valid;
    logic [1:0] ex_hit;
    logic [1:0] wb_hit;

    // index 0 holds rs1 and index 1 holds rs2
    assign src_idx[0] = rs1;
    assign src_idx[1] = rs2;
    assign dflt[0]    = jalr ? operand3 : operand1;
    assign dflt[1]    = operand2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // a load has no result in ex yet so it falls through to writeback
            ex_hit[i] = ex.valid && ex.dest_wen && !ex.load_valid &&
                        (src_idx[i] != `ZERO_REG) && (src_idx[i] == ex.rd);
            wb_hit[i] = wb.valid && wb.dest_wen &&
                        (src_idx[i] != `ZERO_REG) && (src_idx[i] == wb.rd);
            if (ex_hit[i]) begin
                fwd[i] = ex.result;
            end else if (wb_hit[i]) begin
                fwd[i] = wb.data;
            end else if (hold_valid[i]) begin
                fwd[i] = hold_data[i];
            end else begin
                fwd[i] = dflt[i];
            end
        end
    end

    // keep a copy since writeback can move on during a stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 2'b00;
        end else if (flush || decode_ready) begin
            hold_valid <= 2'b00;
        end else if (decode_valid) begin
            hold_valid <= hold_valid | wb_hit;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (decode_valid && wb_hit[i]) begin
                hold_data[i] <= wb.data;
            end
        end
    end

    // for jalr rs1 feeds the target base and the alu keeps the decode operand
    assign src_a       = jalr ? operand1 : fwd[0];
    assign target_base = jalr ? fwd[0] : operand3;
    assign src_b       = fwd[1];

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "exu_defs.svh"

module alu import exu_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src_a,
    input  word_t   src_b,
    output word_t   result,
    output logic    branch_taken
);
    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     eq;
    logic                     lt_s;
    logic                     lt_u;

    // rv64 shifts use the low 6 bits
    assign shamt = src_b[$clog2(`XLEN)-1:0];

    // shared by set and branch compares
    assign eq   = (src_a == src_b);
    assign lt_s = ($signed(src_a) < $signed(src_b));
    assign lt_u = (src_a < src_b);

    always_comb begin
        result       = '0;
        branch_taken = 1'b0;
        case (alu_op)
            op_add:  result = src_a + src_b;
            op_sub:  result = src_a - src_b;
            op_and:  result = src_a & src_b;
            op_or:   result = src_a | src_b;
            op_xor:  result = src_a ^ src_b;
            op_sll:  result = src_a << shamt;
            op_srl:  result = src_a >> shamt;
            op_sra:  result = word_t'($signed(src_a) >>> shamt);
            op_slt:  result = word_t'(lt_s);
            op_sltu: result = word_t'(lt_u);
            // compares only drive the flag
            op_beq:  branch_taken = eq;
            op_bne:  branch_taken = !eq;
            op_blt:  branch_taken = lt_s;
            op_bge:  branch_taken = !lt_s;
            op_bltu: branch_taken = lt_u;
            op_bgeu: branch_taken = !lt_u;
            default: result = '0;
        endcase
    end

endmodule

// ==== target_gen.sv ====
`timescale 1ns/1ps
`include "exu_defs.svh"

module target_gen import exu_pkg::*; (
    input  word_t target_base,
    input  word_t offset,
    input  word_t next_pc,
    input  logic  jump_valid,
    input  logic  branch_valid,
    input  logic  branch_taken,
    output word_t jump_addr,
    output word_t sel_next_pc
);
    word_t sum;
    logic  redirect;

    assign sum       = target_base + offset;
    // jalr needs bit 0 cleared, harmless for the others
    assign jump_addr = {sum[`XLEN-1:1], 1'b0};

    assign redirect    = jump_valid || (branch_valid && branch_taken);
    assign sel_next_pc = redirect ? jump_addr : next_pc;

endmodule

// ==== ex_ls_reg.sv ====
`timescale 1ns/1ps

module ex_ls_reg import exu_pkg::*; (
    input  logic     clk,
    input  logic     decode_ready,
    input  reg_idx_t rd,
    input  logic     dest_wen,
    input  logic     load_valid,
    input  word_t    pc,
    input  word_t    sel_next_pc,
    input  word_t    result,
    ex_ls_if.regs    ex,
    output word_t    ex_pc,
    output word_t    ex_next_pc
);

    // ************************************************************************
    // payload bank, meaningful only while ex valid is set
    // ************************************************************************

    // decode_ready already implies a free or draining slot
    always_ff @(posedge clk) begin
        if (decode_ready) begin
            ex.rd         <= rd;
            ex.dest_wen   <= dest_wen;
            ex.load_valid <= load_valid;
            ex.result     <= result;
        end
    end

    // pcs only go downstream, not into forwarding
    always_ff @(posedge clk) begin
        if (decode_ready) begin
            ex_pc      <= pc;
            ex_next_pc <= sel_next_pc;
        end
    end

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // decode side
    input  logic     decode_valid,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     dest_wen,
    input  word_t    pc,
    input  word_t    next_pc,
    input  alu_op_t  alu_op,
    input  logic     load_valid,
    input  logic     branch_valid,
    input  logic     jump_valid,
    input  logic     jalr,
    input  word_t    operand1,
    input  word_t    operand2,
    input  word_t    operand3,
    input  word_t    operand4,
    output logic     decode_ready,
    output logic     flush,
    // load-store side
    input  logic     ls_flush,
    input  logic     ls_ready,
    output logic     ex_valid,
    output word_t    ex_pc,
    output word_t    ex_next_pc,
    output reg_idx_t ex_rd,
    output logic     ex_dest_wen,
    output logic     ex_load_valid,
    output word_t    ex_result,
    // writeback bypass
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  logic     wb_dest_wen,
    input  word_t    wb_data,
    // fetch redirect
    output logic     jump_flag,
    output word_t    jump_addr
);
    word_t src_a;
    word_t src_b;
    word_t target_base;
    word_t alu_result;
    word_t sel_next_pc;
    logic  branch_taken;

    ex_ls_if  ex_bus ();
    wb_fwd_if wb_bus ();

    assign wb_bus.valid    = wb_valid;
    assign wb_bus.rd       = wb_rd;
    assign wb_bus.dest_wen = wb_dest_wen;
    assign wb_bus.data     = wb_data;

    assign ex_valid      = ex_bus.valid;
    assign ex_rd         = ex_bus.rd;
    assign ex_dest_wen   = ex_bus.dest_wen;
    assign ex_load_valid = ex_bus.load_valid;
    assign ex_result     = ex_bus.result;

    exu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .decode_valid (decode_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .branch_valid (branch_valid),
        .jump_valid   (jump_valid),
        .branch_taken (branch_taken),
        .ls_flush     (ls_flush),
        .ls_ready     (ls_ready),
        .ex           (ex_bus),
        .decode_ready (decode_ready),
        .flush        (flush),
        .jump_flag    (jump_flag)
    );

    operand_fwd u_fwd (
        .clk          (clk),
        .rst_n        (rst_n),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .flush        (flush),
        .rs1          (rs1),
        .rs2          (rs2),
        .jalr         (jalr),
        .operand1     (operand1),
        .operand2     (operand2),
        .operand3     (operand3),
        .ex           (ex_bus),
        .wb           (wb_bus),
        .src_a        (src_a),
        .src_b        (src_b),
        .target_base  (target_base)
    );

    alu u_alu (
        .alu_op       (alu_op),
        .src_a        (src_a),
        .src_b        (src_b),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    target_gen u_target (
        .target_base  (target_base),
        .offset       (operand4),
        .next_pc      (next_pc),
        .jump_valid   (jump_valid),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .jump_addr    (jump_addr),
        .sel_next_pc  (sel_next_pc)
    );

    ex_ls_reg u_ex_ls (
        .clk          (clk),
        .decode_ready (decode_ready),
        .rd           (rd),
        .dest_wen     (dest_wen),
        .load_valid   (load_valid),
        .pc           (pc),
        .sel_next_pc  (sel_next_pc),
        .result       (alu_result),
        .ex           (ex_bus),
        .ex_pc        (ex_pc),
        .ex_next_pc   (ex_next_pc)
    );

endmodule

// ==== tb_exu.sv ====
`timescale 1ns/1ps
`include "exu_defs.svh"

module tb_exu import exu_pkg::*; ();
    logic     clk;
    logic     rst_n;
    logic     decode_valid;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     dest_wen;
    word_t    pc;
    word_t    next_pc;
    alu_op_t  alu_op;
    logic     load_valid;
    logic     branch_valid;
    logic     jump_valid;
    logic     jalr;
    word_t    operand1;
    word_t    operand2;
    word_t    operand3;
    word_t    operand4;
    logic     decode_ready;
    logic     flush;
    logic     ls_flush;
    logic     ls_ready;
    logic     ex_valid;
    word_t    ex_pc;
    word_t    ex_next_pc;
    reg_idx_t ex_rd;
    logic     ex_dest_wen;
    logic     ex_load_valid;
    word_t    ex_result;
    logic     wb_valid;
    reg_idx_t wb_rd;
    logic     wb_dest_wen;
    word_t    wb_data;
    logic     jump_flag;
    word_t    jump_addr;

    // reference model of the ex_ register and the stage state
    logic [31:0] lfsr_state;
    logic        exp_valid;
    logic        exp_wen;
    logic        exp_load;
    logic        exp_loaded;
    reg_idx_t    exp_rd;
    word_t       exp_result;
    word_t       exp_pc;
    word_t       exp_next_pc;
    logic        jump_given;
    logic [1:0]  hold_v;
    word_t       hold_d [2];
    logic        last_jump;

    exu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************************
    // random source and reference model
    // ************************************************************************

    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic word_t rand_word(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`XLEN-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic less_than(word_t a, word_t b, logic signed_cmp);
        // opposite signs decide a signed compare on their own
        if (signed_cmp && (a[`XLEN-1] != b[`XLEN-1])) begin
            return a[`XLEN-1];
        end
        return a < b;
    endfunction

    function automatic word_t model_result(alu_op_t op, word_t a, word_t b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << sh;
            op_srl:  return a >> sh;
            op_sra:  return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
            op_slt:  return {{(`XLEN-1){1'b0}}, less_than(a, b, 1'b1)};
            op_sltu: return {{(`XLEN-1){1'b0}}, less_than(a, b, 1'b0)};
            default: return '0;
        endcase
    endfunction

    function automatic logic model_taken(alu_op_t op, word_t a, word_t b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return less_than(a, b, 1'b1);
            op_bge:  return !less_than(a, b, 1'b1);
            op_bltu: return less_than(a, b, 1'b0);
            op_bgeu: return !less_than(a, b, 1'b0);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic wb_match(reg_idx_t rs);
        return wb_valid && wb_dest_wen && (rs != `ZERO_REG) && (rs == wb_rd);
    endfunction

    // ex result first, then writeback, then the held copy, then decode
    function automatic word_t forward(reg_idx_t rs, word_t dflt, logic hv, word_t hd);
        if (exp_valid && exp_wen && !exp_load && (rs != `ZERO_REG) && (rs == exp_rd)) begin
            return exp_result;
        end else if (wb_match(rs)) begin
            return wb_data;
        end else if (hv) begin
            return hd;
        end
        return dflt;
    endfunction

    // ************************************************************************
    // compare tasks
    // ************************************************************************

    task automatic fail_now();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    // ************************************************************************
    // stimulus
    // ************************************************************************

    task automatic clear_inputs();
        decode_valid = 1'b0;
        rs1          = '0;
        rs2          = '0;
        rd           = '0;
        dest_wen     = 1'b0;
        pc           = '0;
        next_pc      = '0;
        alu_op       = op_add;
        load_valid   = 1'b0;
        branch_valid = 1'b0;
        jump_valid   = 1'b0;
        jalr         = 1'b0;
        operand1     = '0;
        operand2     = '0;
        operand3     = '0;
        operand4     = '0;
        ls_flush     = 1'b0;
        ls_ready     = 1'b1;
        wb_valid     = 1'b0;
        wb_rd        = '0;
        wb_dest_wen  = 1'b0;
        wb_data      = '0;
    endtask

    // small index range so forwarding and conflicts happen often
    task automatic randomize_inputs();
        word_t r;
        decode_valid = (rand_word(3) != '0);
        rs1          = reg_idx_t'(rand_word(2));
        rs2          = reg_idx_t'(rand_word(2));
        rd           = reg_idx_t'(rand_word(2));
        dest_wen     = (rand_word(2) != '0);
        load_valid   = (rand_word(3) == '0);
        r            = rand_word(4);
        alu_op       = alu_op_t'(r[3:0]);
        branch_valid = (alu_op >= op_beq);
        jump_valid   = !branch_valid && (rand_word(3) == '0);
        jalr         = jump_valid && (rand_word(1) != '0);
        pc           = rand_word(`XLEN);
        next_pc      = pc + 4;
        operand1     = rand_word(`XLEN);
        operand2     = (rand_word(2) == '0) ? operand1 : rand_word(`XLEN);
        operand3     = pc;
        operand4     = rand_word(12);
        wb_valid     = (rand_word(1) != '0);
        wb_rd        = reg_idx_t'(rand_word(2));
        wb_dest_wen  = (rand_word(3) != '0);
        wb_data      = rand_word(`XLEN);
        ls_ready     = (rand_word(2) != '0);
        ls_flush     = (rand_word(4) == '0);
    endtask

    // one clock of combinational checks, model update and ex_ register checks
    task automatic run_cycle(output logic accepted);
        word_t a_fwd;
        word_t b_fwd;
        word_t alu_a;
        word_t base;
        word_t target;
        logic  conflict;
        logic  out_free;
        logic  ready_m;
        logic  redirect;
        logic  jump_m;
        #1;
        // rs1 feeds the target base for jalr and the alu otherwise
        a_fwd    = forward(rs1, jalr ? operand3 : operand1, hold_v[0], hold_d[0]);
        b_fwd    = forward(rs2, operand2, hold_v[1], hold_d[1]);
        alu_a    = jalr ? operand1 : a_fwd;
        base     = jalr ? a_fwd : operand3;
        target   = base + operand4;
        target[0] = 1'b0;
        redirect = jump_valid || (branch_valid && model_taken(alu_op, alu_a, b_fwd));
        conflict = exp_valid && exp_wen && exp_load &&
                   (((rs1 != `ZERO_REG) && (rs1 == exp_rd)) ||
                    ((rs2 != `ZERO_REG) && (rs2 == exp_rd)));
        out_free = !exp_valid || ls_ready;
        ready_m  = decode_valid && out_free && !conflict;
        jump_m   = decode_valid && redirect && !jump_given && !conflict;
        check_bit("decode_ready", decode_ready, ready_m);
        check_bit("jump_flag", jump_flag, jump_m);
        check_bit("flush", flush, ls_flush);
        if (jump_m) begin
            check_word("jump_addr", jump_addr, target);
        end
        last_jump = jump_flag;
        accepted  = ready_m;

        // model state after the coming edge
        if (ls_flush || ready_m) begin
            hold_v = '0;
        end else if (decode_valid) begin
            if (wb_match(rs1)) begin
                hold_v[0] = 1'b1;
                hold_d[0] = wb_data;
            end
            if (wb_match(rs2)) begin
                hold_v[1] = 1'b1;
                hold_d[1] = wb_data;
            end
        end
        if (ls_flush || ready_m) begin
            jump_given = 1'b0;
        end else if (jump_m) begin
            jump_given = 1'b1;
        end
        if (ls_flush) begin
            exp_valid = 1'b0;
        end else if (out_free) begin
            exp_valid = ready_m;
        end
        if (ready_m) begin
            exp_rd      = rd;
            exp_wen     = dest_wen;
            exp_load    = load_valid;
            exp_result  = model_result(alu_op, alu_a, b_fwd);
            exp_pc      = pc;
            exp_next_pc = redirect ? target : next_pc;
            exp_loaded  = 1'b1;
        end

        @(negedge clk);
        check_bit("ex_valid", ex_valid, exp_valid);
        if (exp_loaded) begin
            check_idx("ex_rd", ex_rd, exp_rd);
            check_bit("ex_dest_wen", ex_dest_wen, exp_wen);
            check_bit("ex_load_valid", ex_load_valid, exp_load);
            check_word("ex_result", ex_result, exp_result);
            check_word("ex_pc", ex_pc, exp_pc);
            check_word("ex_next_pc", ex_next_pc, exp_next_pc);
        end
    endtask

    task automatic wait_accept(int limit);
        logic acc;
        int   n;
        acc = 1'b0;
        n   = 0;
        while (!acc && (n < limit)) begin
            run_cycle(acc);
            n++;
        end
        if (!acc) begin
            $display("timeout: instruction not accepted within %0d cycles", limit);
            fail_now();
        end
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        logic  acc;
        word_t ld_data;
        word_t op2;
        word_t jump_exp;
        int    pulses;
        lfsr_state  = 32'he00;
        exp_valid   = 1'b0;
        exp_wen     = 1'b0;
        exp_load    = 1'b0;
        exp_loaded  = 1'b0;
        exp_rd      = '0;
        exp_result  = '0;
        exp_pc      = '0;
        exp_next_pc = '0;
        jump_given  = 1'b0;
        hold_v      = '0;
        last_jump   = 1'b0;
        rst_n       = 1'b0;
        clear_inputs();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("jump_flag", jump_flag, 1'b0);

        // random traffic with stalls, forwarding, branches and flushes
        repeat (400) begin
            randomize_inputs();
            run_cycle(acc);
        end

        // flush drops a valid entry that back-pressure would otherwise hold
        clear_inputs();
        decode_valid = 1'b1;
        rd           = 5'd3;
        dest_wen     = 1'b1;
        operand1     = rand_word(`XLEN);
        wait_accept(20);
        clear_inputs();
        ls_ready = 1'b0;
        ls_flush = 1'b1;
        run_cycle(acc);
        ls_flush = 1'b0;
        ls_ready = 1'b1;
        check_bit("ex_valid", ex_valid, 1'b0);

        // dependent add stalls behind a load into x5
        decode_valid = 1'b1;
        rd           = 5'd5;
        dest_wen     = 1'b1;
        load_valid   = 1'b1;
        wait_accept(4);
        clear_inputs();
        ld_data      = rand_word(`XLEN);
        op2          = rand_word(`XLEN);
        ls_ready     = 1'b0;
        decode_valid = 1'b1;
        rs1          = 5'd5;
        rd           = 5'd6;
        dest_wen     = 1'b1;
        operand1     = rand_word(`XLEN);
        operand2     = op2;
        repeat (3) run_cycle(acc);
        wb_valid    = 1'b1;
        wb_rd       = 5'd5;
        wb_dest_wen = 1'b1;
        wb_data     = ld_data;
        run_cycle(acc);
        // the held copy carries the data once writeback moves on
        wb_valid = 1'b0;
        wb_data  = ~ld_data;
        ls_ready = 1'b1;
        wait_accept(8);
        check_word("ex_result", ex_result, ld_data + op2);

        // jalr through x6 under back-pressure
        clear_inputs();
        ls_ready     = 1'b0;
        decode_valid = 1'b1;
        jump_valid   = 1'b1;
        jalr         = 1'b1;
        rs1          = 5'd6;
        rd           = 5'd1;
        dest_wen     = 1'b1;
        operand2     = 64'h4;
        operand4     = 64'h123;
        pulses       = 0;
        repeat (4) begin
            run_cycle(acc);
            if (last_jump) begin
                pulses++;
            end
        end
        check_bit("jump_flag pulses", pulses == 1, 1'b1);
        ls_ready = 1'b1;
        wait_accept(4);
        jump_exp    = ld_data + op2 + 64'h123;
        jump_exp[0] = 1'b0;
        check_word("ex_next_pc", ex_next_pc, jump_exp);

        // beq not taken keeps next_pc
        clear_inputs();
        decode_valid = 1'b1;
        branch_valid = 1'b1;
        alu_op       = op_beq;
        operand1     = 64'h1;
        operand2     = 64'h2;
        operand3     = 64'h8000_1000;
        operand4     = 64'h20;
        next_pc      = 64'h8000_0040;
        wait_accept(4);
        check_bit("jump_flag", last_jump, 1'b0);
        check_word("ex_next_pc", ex_next_pc, 64'h8000_0040);
        clear_inputs();
        run_cycle(acc);

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
exu_pkg.sv
exu_ifs.sv
exu_ctrl.sv
operand_fwd.sv
alu.sv
target_gen.sv
ex_ls_reg.sv
exu_top.sv
tb_exu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_exu -o tb_exu > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_exu > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
exit 1
